//--- hdl/egress_forward.sv
`timescale 1ns/1ns
module egress_forward (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  switch_pkg::buf_wr_t                                  wr,
    input  logic                                                 desc_valid,
    input  switch_pkg::frame_desc_t                              desc,
    output logic [1:0]                                           slot_free,
    output switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] tx,
    input  switch_pkg::port_map_t                                tx_ready
);

    typedef enum logic {
        ST_IDLE,
        ST_SEND
    } egress_state_t;

    egress_state_t           state;
    switch_pkg::byte_t       mem [2*switch_pkg::MAX_FRAME];  // two slots back to back
    switch_pkg::frame_desc_t hold [2];
    switch_pkg::frame_desc_t head;
    switch_pkg::frame_desc_t cur;
    logic                    hold_wp;
    logic                    hold_rp;
    logic [1:0]              hold_cnt;
    logic [1:0]              busy;
    logic [1:0]              set_mask;
    logic [1:0]              clr_mask;
    logic                    take;
    logic                    advance;
    logic                    at_end;
    switch_pkg::byte_t       rd_data;
    logic [$clog2(switch_pkg::MAX_FRAME)-1:0] rd_idx;

    assign head      = hold[hold_rp];
    assign take      = state == ST_IDLE && hold_cnt != 2'd0;
    assign at_end    = switch_pkg::frame_len_t'(rd_idx) == cur.len - 1'b1;
    // byte moves only when every mapped port is ready
    assign advance   = state == ST_SEND && (tx_ready & cur.map) == cur.map;
    assign rd_data   = mem[{cur.slot, rd_idx}];
    assign slot_free = ~busy;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (wr.en) set_mask[wr.slot] = 1'b1;
        if (advance && at_end) clr_mask[cur.slot] = 1'b1;
        if (take && head.map == '0) clr_mask[head.slot] = 1'b1;  // nothing to send
    end

    always_comb begin
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
            tx[p].valid = state == ST_SEND && cur.map[p];
            tx[p].last  = state == ST_SEND && cur.map[p] && at_end;
            tx[p].data  = rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) mem[{wr.slot, wr.addr}] <= wr.data;
        if (desc_valid) hold[hold_wp] <= desc;
        if (take) cur <= head;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            busy     <= '0;
            hold_wp  <= 1'b0;
            hold_rp  <= 1'b0;
            hold_cnt <= '0;
            rd_idx   <= '0;
        end else begin
            busy     <= (busy | set_mask) & ~clr_mask;
            hold_wp  <= hold_wp ^ desc_valid;
            hold_rp  <= hold_rp ^ take;
            hold_cnt <= hold_cnt + {1'b0, desc_valid} - {1'b0, take};
            case (state)
                ST_IDLE: begin
                    rd_idx <= '0;
                    if (take && head.map != '0) state <= ST_SEND;
                end
                default: begin
                    if (advance) begin
                        rd_idx <= rd_idx + 1'b1;
                        if (at_end) state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/frame_parser.sv
`timescale 1ns/1ns
module frame_parser (
    input  logic                    clk,
    input  logic                    rst_n,
    input  switch_pkg::stream_beat_t beat,
    input  switch_pkg::port_id_t    src_port,
    output logic                    accept,
    input  logic [1:0]              slot_free,
    output switch_pkg::buf_wr_t     wr,
    output logic                    req,
    output switch_pkg::lookup_req_t lookup,
    input  logic                    ack,
    input  switch_pkg::port_map_t   dest_map,
    output logic                    desc_valid,
    output switch_pkg::frame_desc_t desc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE,
        ST_LOOKUP,
        ST_HANDOFF
    } parser_state_t;

    parser_state_t          state;
    switch_pkg::frame_len_t cnt;
    switch_pkg::slot_t      cur_slot;
    switch_pkg::slot_t      pick_slot;
    switch_pkg::port_id_t   src_q;
    switch_pkg::mac_addr_t  dst_mac;
    switch_pkg::mac_addr_t  src_mac;
    switch_pkg::port_map_t  map_q;
    logic                   xfer;
    logic                   full;

    assign pick_slot = slot_free[0] ? 1'b0 : 1'b1;
    // first byte is taken in idle only when a slot is free
    assign accept    = (state == ST_IDLE && |slot_free) || state == ST_STORE;
    assign xfer      = beat.valid && accept;
    assign full      = cnt == switch_pkg::frame_len_t'(switch_pkg::MAX_FRAME);

    always_comb begin
        wr.en   = xfer && !full;  // overflow bytes dropped
        wr.slot = (state == ST_IDLE) ? pick_slot : cur_slot;
        wr.addr = cnt[$clog2(switch_pkg::MAX_FRAME)-1:0];
        wr.data = beat.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (xfer) state <= beat.last ? ST_LOOKUP : ST_STORE;
                end
                ST_STORE: begin
                    if (xfer && beat.last) state <= ST_LOOKUP;
                end
                ST_LOOKUP: begin
                    if (ack) state <= ST_HANDOFF;
                end
                default: state <= ST_IDLE;
            endcase
            if (state == ST_HANDOFF) cnt <= '0;
            else if (xfer && !full) cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && state == ST_IDLE) begin
            cur_slot <= pick_slot;
            src_q    <= src_port;
        end
        if (xfer && cnt < 7'd6) dst_mac <= {dst_mac[39:0], beat.data};       // bytes 0..5
        else if (xfer && cnt < 7'd12) src_mac <= {src_mac[39:0], beat.data};  // bytes 6..11
        if (state == ST_LOOKUP && ack) map_q <= dest_map;
    end

    assign req        = state == ST_LOOKUP;
    assign lookup     = '{dst: dst_mac, src: src_mac, src_port: src_q};
    assign desc_valid = state == ST_HANDOFF;
    assign desc       = '{slot: cur_slot, len: cnt, map: map_q};

endmodule

//--- hdl/mac_table.sv
`timescale 1ns/1ns
module mac_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  switch_pkg::lookup_req_t lookup,
    output logic                    ack,
    output switch_pkg::port_map_t   dest_map
);

    logic [switch_pkg::TABLE_DEPTH-1:0] entry_valid;
    switch_pkg::mac_addr_t              entry_mac  [switch_pkg::TABLE_DEPTH];
    switch_pkg::port_id_t               entry_port [switch_pkg::TABLE_DEPTH];

    switch_pkg::table_idx_t dst_idx;
    switch_pkg::table_idx_t src_idx;
    switch_pkg::port_map_t  src_bit;
    switch_pkg::port_map_t  map_c;
    switch_pkg::port_map_t  map_q;
    logic                   hit;
    logic                   learn_q;  // second cycle
    logic                   ack_q;

    // byte fold, then nibble fold
    function automatic switch_pkg::table_idx_t hash_idx(input switch_pkg::mac_addr_t a);
        switch_pkg::byte_t x;
        x = a[47:40] ^ a[39:32] ^ a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
        return x[7:4] ^ x[3:0];
    endfunction

    assign dst_idx = hash_idx(lookup.dst);
    assign src_idx = hash_idx(lookup.src);

    always_comb begin
        src_bit = switch_pkg::port_map_t'(1) << lookup.src_port;
        hit     = entry_valid[dst_idx] && entry_mac[dst_idx] == lookup.dst;
        if (lookup.dst == '1) map_c = ~src_bit;  // broadcast
        else if (hit) map_c = (switch_pkg::port_map_t'(1) << entry_port[dst_idx]) & ~src_bit;
        else map_c = ~src_bit;                   // unknown, flood
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            learn_q     <= 1'b0;
            ack_q       <= 1'b0;
            entry_valid <= '0;
        end else begin
            learn_q <= req && !learn_q && !ack_q;
            ack_q   <= learn_q;
            if (learn_q) entry_valid[src_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !learn_q && !ack_q) map_q <= map_c;  // lookup before learning
        if (learn_q) begin
            entry_mac[src_idx]  <= lookup.src;
            entry_port[src_idx] <= lookup.src_port;
        end
    end

    assign ack      = ack_q;
    assign dest_map = map_q;

endmodule

//--- hdl/port_arbiter.sv
`timescale 1ns/1ns
module port_arbiter (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] rx,
    output switch_pkg::port_map_t                                rx_ready,
    input  logic                                                 accept,
    output switch_pkg::stream_beat_t                             beat,
    output switch_pkg::port_id_t                                 src_port
);

    logic                 busy;   // grant held for a whole frame
    logic                 found;
    switch_pkg::port_id_t grant;
    switch_pkg::port_id_t ptr;    // search start
    switch_pkg::port_id_t pick;
    switch_pkg::port_id_t idx;

    // first valid port at or after ptr
    always_comb begin
        found = 1'b0;
        pick  = ptr;
        idx   = ptr;
        for (int i = 0; i < switch_pkg::NUM_PORTS; i++) begin
            idx = ptr + switch_pkg::port_id_t'(i);
            if (!found && rx[idx].valid) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            grant <= '0;
            ptr   <= '0;
        end else if (!busy) begin
            busy  <= found;
            grant <= pick;
        end else if (beat.valid && accept && beat.last) begin
            busy <= 1'b0;
            ptr  <= grant + 1'b1;  // next search after the served port
        end
    end

    assign beat     = busy ? rx[grant] : '0;
    assign src_port = grant;

    always_comb begin
        rx_ready = '0;
        if (busy) rx_ready[grant] = accept;
    end

endmodule

//--- hdl/switch_core.sv
`timescale 1ns/1ns
module switch_core (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] rx,
    output switch_pkg::port_map_t                                rx_ready,
    output switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] tx,
    input  switch_pkg::port_map_t                                tx_ready
);

    switch_pkg::stream_beat_t beat;
    switch_pkg::port_id_t     src_port;
    logic                     accept;
    logic [1:0]               slot_free;
    switch_pkg::buf_wr_t      wr;
    logic                     req;
    logic                     ack;
    switch_pkg::lookup_req_t  lookup;
    switch_pkg::port_map_t    dest_map;
    logic                     desc_valid;
    switch_pkg::frame_desc_t  desc;

    port_arbiter u_port_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .rx(rx),
        .rx_ready(rx_ready),
        .accept(accept),
        .beat(beat),
        .src_port(src_port)
    );

    frame_parser u_frame_parser (
        .clk(clk),
        .rst_n(rst_n),
        .beat(beat),
        .src_port(src_port),
        .accept(accept),
        .slot_free(slot_free),
        .wr(wr),
        .req(req),
        .lookup(lookup),
        .ack(ack),
        .dest_map(dest_map),
        .desc_valid(desc_valid),
        .desc(desc)
    );

    mac_table u_mac_table (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .lookup(lookup),
        .ack(ack),
        .dest_map(dest_map)
    );

    egress_forward u_egress_forward (
        .clk(clk),
        .rst_n(rst_n),
        .wr(wr),
        .desc_valid(desc_valid),
        .desc(desc),
        .slot_free(slot_free),
        .tx(tx),
        .tx_ready(tx_ready)
    );

endmodule

//--- hdl/switch_pkg.sv
package switch_pkg;

    localparam int NUM_PORTS   = 4;
    localparam int MAX_FRAME   = 64;   // bytes per buffer slot
    localparam int TABLE_DEPTH = 16;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [1:0]  port_id_t;
    typedef logic [3:0]  port_map_t;   // one bit per port
    typedef logic [6:0]  frame_len_t;  // holds MAX_FRAME itself
    typedef logic        slot_t;
    typedef logic [3:0]  table_idx_t;

    // one byte on a rx or tx port
    typedef struct packed {
        logic  valid;
        logic  last;
        byte_t data;
    } stream_beat_t;

    typedef struct packed {
        mac_addr_t dst;
        mac_addr_t src;
        port_id_t  src_port;
    } lookup_req_t;

    typedef struct packed {
        slot_t      slot;
        frame_len_t len;
        port_map_t  map;
    } frame_desc_t;

    typedef struct packed {
        logic                         en;
        slot_t                        slot;
        logic [$clog2(MAX_FRAME)-1:0] addr;  // byte offset in slot
        byte_t                        data;
    } buf_wr_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run from the project root
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_switch \
    -f tb.f -o sim_switch || exit 1
./obj_dir/sim_switch > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && exit 1
grep -q "All tests passed!" sim.log || exit 1
echo "simulation passed"

//--- tb.f
hdl/switch_pkg.sv
hdl/port_arbiter.sv
hdl/frame_parser.sv
hdl/mac_table.sv
hdl/egress_forward.sv
hdl/switch_core.sv
tests/switch_assert.sv
tests/switch_monitor.sv
tests/tb_switch.sv

//--- tests/switch_assert.sv
`timescale 1ns/1ns
module switch_assert (
    input logic                                                 clk,
    input logic                                                 rst_n,
    input logic                                                 req,
    input logic                                                 ack,
    input switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] tx,
    input switch_pkg::port_map_t                                tx_ready
);

    int         n_fail = 0;
    logic [3:0] sel;

    always_comb begin
        for (int p = 0; p < switch_pkg::NUM_PORTS; p++) sel[p] = tx[p].valid;
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n) req && !ack |=> req)
        else begin $error("req dropped before ack"); n_fail++; end

    ack_delay: assert property (@(posedge clk) disable iff (!rst_n) $rose(req) |-> ##2 ack)
        else begin $error("ack not 2 cycles after req"); n_fail++; end

    // valid may not change while a selected port stalls
    tx_held: assert property (@(posedge clk) disable iff (!rst_n)
        sel != '0 && (tx_ready & sel) != sel |=> $stable(sel))
        else begin $error("tx valid changed before all ports ready"); n_fail++; end

endmodule

bind switch_core switch_assert u_switch_assert (
    .clk(clk),
    .rst_n(rst_n),
    .req(req),
    .ack(ack),
    .tx(tx),
    .tx_ready(tx_ready)
);

//--- tests/switch_golden.txt
# name group src_port length dst_mac src_mac expected_map
# macs in hex, map is one hex digit with bit n for port n
flood_p0     0  0 16 020000000051 020000000011 e
learn_p1     1  1 20 020000000011 020000000021 1
flood_p2     2  2 18 020000000051 020000000031 b
flood_p3     3  3 14 020000000051 020000000041 7
to_p3        4  0 24 020000000041 020000000011 8
to_p2        5  1 15 020000000031 020000000021 4
same_p0      6  0 17 020000000011 020000000011 0
bcast_p2     7  2 22 ffffffffffff 020000000031 b
pair_a       8  0 30 020000000021 020000000011 2
pair_b       8  3 26 020000000031 020000000041 4
pair_c       9  1 40 020000000051 020000000021 d
pair_d       9  2 33 020000000041 020000000031 8
bcast_p3    10  3 19 ffffffffffff 020000000041 7
same_p3     11  3 16 020000000041 020000000041 0
after_same  12  2 21 020000000011 020000000031 1
quad_a      13  0 28 020000000031 020000000011 4
quad_b      13  1 28 020000000041 020000000021 8
quad_c      13  2 35 020000000021 020000000031 2
quad_d      13  3 45 020000000011 020000000041 1
max_len     14  1 64 ffffffffffff 020000000021 d

//--- tests/switch_monitor.sv
`timescale 1ns/1ns
module switch_monitor (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] rx,
    input  switch_pkg::port_map_t                                rx_ready,
    input  switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] tx,
    input  switch_pkg::port_map_t                                tx_ready,
    input  logic [switch_pkg::NUM_PORTS-1:0][7:0]                port_test,
    output int                                                   pass_cnt,
    output int                                                   fail_cnt,
    output int                                                   done_cnt
);

    string      names    [64];
    logic [3:0] gold_map [64];
    logic       bad      [64];
    logic [7:0] frame_bytes [64][64];
    int         frame_len   [64];
    logic [15:0] tbl_valid = '0;   // model of the address table
    logic [47:0] tbl_mac  [16];
    logic [1:0]  tbl_port [16];
    logic [7:0] rx_buf [$];
    logic [7:0] tx_buf [$];
    int         exp_test [$];
    logic [3:0] exp_map  [$];
    logic [3:0] tx_set;
    logic [3:0] tx_first;
    logic [7:0] tx_data;
    logic       tx_last;
    logic       tx_split = 1'b0;  // ports disagreed during this frame
    int n_pass = 0;
    int n_fail = 0;
    int n_done = 0;

    assign pass_cnt = n_pass;
    assign fail_cnt = n_fail;
    assign done_cnt = n_done;

    task automatic register_test(input int k, input string nm, input logic [3:0] m);
        names[k]    = nm;
        gold_map[k] = m;
    endtask

    function automatic logic [3:0] fold_hash(input logic [47:0] mac);
        logic [7:0] acc;
        acc = 8'h00;
        for (int b = 0; b < 6; b++) acc ^= mac[8*b +: 8];
        return acc[7:4] ^ acc[3:0];
    endfunction

    function automatic logic [3:0] model_map(input logic [47:0] dst, input logic [1:0] sp);
        logic [3:0] others;
        logic [3:0] h;
        others = ~(4'b0001 << sp);
        h      = fold_hash(dst);
        if (dst == '1) return others;
        if (tbl_valid[h] && tbl_mac[h] == dst) return (4'b0001 << tbl_port[h]) & others;
        return others;  // unknown
    endfunction

    task automatic close_test(input int k, input logic ok);
        if (ok) begin
            $display("PASS %s", names[k]);
            n_pass++;
        end else begin
            $display("FAIL %s", names[k]);
            n_fail++;
        end
        n_done++;
    endtask

    task automatic finish_rx(input int p);
        int k;
        logic [47:0] dst;
        logic [47:0] src;
        logic [3:0]  m;
        k   = int'(port_test[p]);
        dst = '0;
        src = '0;
        for (int i = 0; i < 6; i++) dst = {dst[39:0], rx_buf[i]};
        for (int i = 6; i < 12; i++) src = {src[39:0], rx_buf[i]};
        m = model_map(dst, 2'(p));
        tbl_valid[fold_hash(src)] = 1'b1;  // learn after lookup
        tbl_mac[fold_hash(src)]   = src;
        tbl_port[fold_hash(src)]  = 2'(p);
        bad[k] = m != gold_map[k];
        if (bad[k])
            $display("ERROR %s port map model vs golden: expected %h actual %h",
                     names[k], gold_map[k], m);
        frame_len[k] = rx_buf.size() < 64 ? rx_buf.size() : 64;
        for (int i = 0; i < frame_len[k]; i++) frame_bytes[k][i] = rx_buf[i];
        if (m == 4'h0) close_test(k, !bad[k]);  // nothing should leave
        else begin
            exp_test.push_back(k);
            exp_map.push_back(m);
        end
        rx_buf.delete();
    endtask

    task automatic finish_tx();
        int k;
        logic [3:0] m;
        logic ok;
        if (exp_test.size() == 0) begin
            $display("a frame left on ports %b while no frame was expected", tx_first);
            n_fail++;
        end else begin
            k  = exp_test.pop_front();
            m  = exp_map.pop_front();
            ok = !bad[k];
            if (tx_first != m) begin
                $display("ERROR %s port map: expected %b actual %b", names[k], m, tx_first);
                ok = 1'b0;
            end else if (tx_split) begin
                $display("%s: the selected tx ports did not carry the same bytes", names[k]);
                ok = 1'b0;
            end else if (tx_buf.size() != frame_len[k]) begin
                $display("ERROR %s length: expected %0d actual %0d",
                         names[k], frame_len[k], tx_buf.size());
                ok = 1'b0;
            end else begin
                for (int i = 0; i < frame_len[k]; i++) begin
                    if (ok && tx_buf[i] != frame_bytes[k][i]) begin
                        $display("ERROR %s byte %0d: expected %h actual %h",
                                 names[k], i, frame_bytes[k][i], tx_buf[i]);
                        ok = 1'b0;
                    end
                end
            end
            close_test(k, ok);
        end
        tx_buf.delete();
        tx_split = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                if (rx[p].valid && rx_ready[p]) begin
                    rx_buf.push_back(rx[p].data);
                    if (rx[p].last) finish_rx(p);
                end
            end
            tx_set  = '0;
            tx_data = '0;
            tx_last = 1'b0;
            for (int p = 0; p < switch_pkg::NUM_PORTS; p++) begin
                if (tx[p].valid) begin
                    // every valid port must show the same byte
                    if (tx_set != '0 && (tx[p].data != tx_data || tx[p].last != tx_last))
                        tx_split = 1'b1;
                    tx_set[p] = 1'b1;
                    tx_data   = tx[p].data;
                    tx_last   = tx[p].last;
                end
            end
            // a byte moves when all valid ports are ready
            if (tx_set != '0 && (tx_ready & tx_set) == tx_set) begin
                if (tx_buf.size() == 0) tx_first = tx_set;
                else if (tx_set != tx_first) tx_split = 1'b1;  // port set changed
                tx_buf.push_back(tx_data);
                if (tx_last) finish_tx();
            end
        end
    end

endmodule

//--- tests/tb_switch.sv
`timescale 1ns/1ns
module tb_switch;

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_FACTOR = 8;
    localparam int MAX_TESTS      = 64;

    logic clk = 1'b0;
    logic rst_n;
    switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] rx;
    switch_pkg::port_map_t                                rx_ready;
    switch_pkg::stream_beat_t [switch_pkg::NUM_PORTS-1:0] tx;
    switch_pkg::port_map_t                                tx_ready;
    logic [switch_pkg::NUM_PORTS-1:0][7:0]                port_test;

    int seed = 34;
    string             t_name  [MAX_TESTS];
    int                t_grp   [MAX_TESTS];
    int                t_port  [MAX_TESTS];
    int                t_len   [MAX_TESTS];
    switch_pkg::byte_t t_bytes [MAX_TESTS][switch_pkg::MAX_FRAME];
    int n_tests     = 0;
    int total_bytes = 0;
    int cycles      = 0;
    int limit       = 0;
    int rnd;
    int pass_cnt;
    int fail_cnt;
    int done_cnt;

    always #(CLK_PERIOD/2) clk = ~clk;

    switch_core UUT (
        .clk(clk),
        .rst_n(rst_n),
        .rx(rx),
        .rx_ready(rx_ready),
        .tx(tx),
        .tx_ready(tx_ready)
    );

    switch_monitor u_monitor (
        .clk(clk),
        .rst_n(rst_n),
        .rx(rx),
        .rx_ready(rx_ready),
        .tx(tx),
        .tx_ready(tx_ready),
        .port_test(port_test),
        .pass_cnt(pass_cnt),
        .fail_cnt(fail_cnt),
        .done_cnt(done_cnt)
    );

    task automatic load_golden();
        int fd;
        int n;
        int g;
        int p;
        int l;
        int r;
        string line;
        string nm;
        logic [47:0] d;
        logic [47:0] s;
        logic [3:0]  m;
        fd = $fopen("tests/switch_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/switch_golden.txt, no tests loaded");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r > 0 && line.len() > 4 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d %d %h %h %h", nm, g, p, l, d, s, m);
                if (n == 7 && n_tests < MAX_TESTS) begin
                    t_name[n_tests] = nm;
                    t_grp[n_tests]  = g;
                    t_port[n_tests] = p;
                    t_len[n_tests]  = l;
                    for (int b = 0; b < switch_pkg::MAX_FRAME; b++) begin
                        rnd = $random(seed);
                        if (b < 6) t_bytes[n_tests][b] = d[47-8*b -: 8];
                        else if (b < 12) t_bytes[n_tests][b] = s[47-8*(b-6) -: 8];
                        else t_bytes[n_tests][b] = rnd[7:0];  // payload
                    end
                    u_monitor.register_test(n_tests, nm, m);
                    total_bytes += l;
                    n_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one frame on its port, byte by byte under valid/ready
    task automatic send_frame(input int k);
        int p;
        p = t_port[k];
        port_test[p] = 8'(k);
        for (int b = 0; b < t_len[k]; b++) begin
            @(negedge clk);
            rx[p].valid = 1'b1;
            rx[p].last  = (b == t_len[k] - 1);
            rx[p].data  = t_bytes[k][b];
            do @(posedge clk); while (!rx_ready[p]);
        end
        @(negedge clk);
        rx[p] = '0;
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            rnd = $random(seed);
            for (int i = 0; i < switch_pkg::NUM_PORTS; i++)
                tx_ready[i] = rnd[2*i +: 2] != 2'b00;  // ready 3 times in 4
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: frames still pending after %0d cycles", limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int i;
        int j;
        int g;
        rst_n     = 1'b0;
        rx        = '0;
        tx_ready  = '0;
        port_test = '0;
        load_golden();
        limit = TIMEOUT_FACTOR * total_bytes + 200;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        i = 0;
        while (i < n_tests) begin
            g = t_grp[i];
            j = i;
            while (j < n_tests && t_grp[j] == g) begin
                fork
                    automatic int k = j;
                    send_frame(k);
                join_none
                j++;
            end
            wait fork;
            wait (done_cnt >= j);  // whole group has left
            i = j;
        end
        repeat (2) @(negedge clk);
        $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_tests, pass_cnt, fail_cnt, UUT.u_switch_assert.n_fail);
        if (fail_cnt == 0 && n_tests > 0 && UUT.u_switch_assert.n_fail == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
